/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK
FAIL_MSG  ?= Test FAILED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dcache.f */
hdl/dcache_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_bus_master.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/tb_mem_model.sv
verif/tb_dcache.sv

/* hdl/dcache_bus_master.sv */
`timescale 1ns/1ps

module dcache_bus_master import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cache_addr_u                 req_addr,
    input  logic [tag_bits-1:0]         victim_tag,
    input  logic [line_words-1:0][31:0] victim_line,
    input  logic                        fill_start,
    input  logic                        wb_start,
    output logic [31:0]                 ar_addr,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  logic [31:0]                 r_data,
    input  logic                        r_valid,
    input  logic                        r_last,
    output logic                        r_ready,
    output logic [31:0]                 aw_addr,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output logic [31:0]                 w_data,
    output logic                        w_valid,
    output logic                        w_last,
    input  logic                        w_ready,
    output logic [offset_bits-1:0]      fill_beat,
    output logic                        fill_we,
    output logic [31:0]                 fill_data,
    output logic                        fill_done,
    output logic                        wb_done
);

    logic                        fill_busy;
    logic [offset_bits-1:0]      wb_cnt;
    logic [line_words-1:0][31:0] wb_buf;
    cache_addr_u                 fill_addr;
    cache_addr_u                 wb_addr;

    // refill engine
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ar_valid  <= 1'b0;
            fill_busy <= 1'b0;
            fill_done <= 1'b0;
            fill_beat <= '0;
        end else if (fill_start) begin
            ar_valid  <= 1'b1;
            fill_busy <= 1'b1;
            fill_done <= 1'b0;
            fill_beat <= '0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
            end
            if (fill_we) begin
                fill_beat <= fill_beat + 1'b1;
                if (r_last) begin
                    fill_busy <= 1'b0;
                    fill_done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        fill_addr            = req_addr;
        fill_addr.f.offset   = '0;
        fill_addr.f.byte_sel = '0;
    end

    assign ar_addr   = fill_addr.word;
    assign r_ready   = fill_busy;
    assign fill_we   = r_valid && r_ready;
    assign fill_data = r_data;

    // writeback engine, independent of the refill
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            w_last   <= 1'b0;
            wb_done  <= 1'b0;
            wb_cnt   <= '0;
        end else if (wb_start) begin
            aw_valid <= 1'b1;
            wb_done  <= 1'b0;
            wb_cnt   <= '0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                w_valid  <= 1'b1;
            end
            if (w_valid && w_ready) begin
                wb_cnt <= wb_cnt + 1'b1;
                w_last <= (wb_cnt == 3'd6);
                if (w_last) begin
                    w_valid <= 1'b0;
                    wb_done <= 1'b1;
                end
            end
        end
    end

    // victim line and its own address, held for the whole burst
    always_ff @(posedge clk) begin
        if (wb_start) begin
            wb_buf             <= victim_line;
            wb_addr.f.tag      <= victim_tag;
            wb_addr.f.index    <= req_addr.f.index;
            wb_addr.f.offset   <= '0;
            wb_addr.f.byte_sel <= '0;
        end
    end

    assign aw_addr = wb_addr.word;
    assign w_data  = wb_buf[wb_cnt];

    // last flag lines up with the eighth data beat
    a_wlast_beat: assert property (
        @(posedge clk) disable iff (!arst_n)
        w_last |-> w_valid && (wb_cnt == 3'd7)
    );

endmodule

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [31:0]                     addr,
    input  logic                            rd_en,
    input  logic [3:0]                      wr_be,
    input  logic [31:0]                     wr_data,
    input  logic [1:0]                      hit_way,
    input  logic                            victim_way,
    input  logic                            victim_dirty,
    input  logic [offset_bits-1:0]          fill_beat,
    input  logic                            fill_we,
    input  logic [31:0]                     fill_data,
    input  logic                            fill_done,
    input  logic                            wb_done,
    input  logic [31:0]                     hit_word,
    output cache_addr_u                     req_addr,
    output cache_addr_u                     lookup_addr,
    output logic [31:0]                     rd_data,
    output logic                            rd_valid,
    output logic                            wr_done,
    output logic                            lru_touch,
    output logic                            wr_hit,
    output logic                            line_alloc,
    output logic                            alloc_dirty,
    output logic                            fill_start,
    output logic                            wb_start,
    output logic [1:0][line_words-1:0][3:0] bank_we,
    output logic [31:0]                     bank_wdata
);

    ctrl_state_e state;
    cache_addr_u addr_r;
    logic        rd_r;
    logic [3:0]  be_r;
    logic [31:0] wdata_r;
    logic        way_r;
    logic        miss_r;
    logic        wb_pending;
    logic [31:0] fill_word;
    logic        is_hit;
    logic        accept;

    assign is_hit = |hit_way;
    assign accept = (state == idle) && (rd_en || (|wr_be));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            rd_r       <= 1'b0;
            be_r       <= 4'b0;
            miss_r     <= 1'b0;
            wb_pending <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        rd_r  <= rd_en;
                        be_r  <= wr_be;
                        state <= compare;
                    end
                end
                compare: begin
                    miss_r <= !is_hit;
                    if (is_hit) begin
                        state <= rd_r ? idle : update;
                    end else begin
                        wb_pending <= victim_dirty;
                        state      <= memory;
                    end
                end
                memory: begin
                    // refill done, and the writeback too if one was started
                    if (fill_done && (!wb_pending || wb_done)) begin
                        state <= update;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request payload and refill capture
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_r  <= cache_addr_u'(addr);
            wdata_r <= wr_data;
        end
        if (state == compare) begin
            way_r <= is_hit ? hit_way[1] : victim_way;
        end
        if (fill_we && (fill_beat == addr_r.f.offset)) begin
            fill_word <= fill_data;
        end
    end

    // stores see the live address while idle
    assign lookup_addr = (state == idle) ? cache_addr_u'(addr) : addr_r;
    assign req_addr    = addr_r;

    assign lru_touch   = (state == compare) && is_hit;
    assign wr_hit      = lru_touch && !rd_r;
    assign fill_start  = (state == compare) && !is_hit;
    assign wb_start    = fill_start && victim_dirty;
    assign line_alloc  = (state == update) && miss_r;
    assign alloc_dirty = !rd_r;

    assign rd_valid = rd_r && (((state == compare) && is_hit) || (state == update));
    assign rd_data  = (state == compare) ? hit_word : fill_word;
    assign wr_done  = !rd_r && (state == update);

    // refill beats fill whole words, a write merges under its byte enables
    always_comb begin
        bank_we    = '0;
        bank_wdata = wdata_r;
        if ((state == memory) && fill_we) begin
            bank_we[way_r][fill_beat] = 4'hf;
            bank_wdata                = fill_data;
        end else if ((state == update) && !rd_r) begin
            bank_we[way_r][addr_r.f.offset] = be_r;
        end
    end

    // processor never asks for a read and a write at once
    a_req_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == idle) |-> !(rd_en && (|wr_be))
    );

endmodule

/* hdl/dcache_data_store.sv */
`timescale 1ns/1ps

module dcache_data_store import dcache_pkg::*; (
    input  logic                            clk,
    input  cache_addr_u                     lookup_addr,
    input  cache_addr_u                     req_addr,
    input  logic [1:0]                      hit_way,
    input  logic                            victim_way,
    input  logic [1:0][line_words-1:0][3:0] bank_we,
    input  logic [31:0]                     bank_wdata,
    output logic [31:0]                     hit_word,
    output logic [line_words-1:0][31:0]     victim_line
);

    localparam int sets = 2 ** index_bits;

    logic [31:0] bank_q [2][line_words];

    // one 128 x 32 bank per way and word
    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < line_words; b++) begin : g_bank
            logic [31:0] mem [sets];

            always_ff @(posedge clk) begin
                for (int i = 0; i < 4; i++) begin
                    if (bank_we[w][b][i]) begin
                        mem[req_addr.f.index][i*8 +: 8] <= bank_wdata[i*8 +: 8];
                    end
                end
                bank_q[w][b] <= mem[lookup_addr.f.index];
            end
        end
    end

    // hit is one-hot, so bit 1 names the way
    assign hit_word = bank_q[hit_way[1]][req_addr.f.offset];

    // full victim line for the writeback buffer
    always_comb begin
        for (int b = 0; b < line_words; b++) begin
            victim_line[b] = bank_q[victim_way][b];
        end
    end

endmodule

/* hdl/dcache_pkg.sv */
package dcache_pkg;

    // address field widths
    localparam int tag_bits    = 20;
    localparam int index_bits  = 7;
    localparam int offset_bits = 3;
    localparam int word_bits   = 2;

    // words per line, also beats per burst
    localparam int line_words = 8;

    // one address split into its cache fields
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
        logic [word_bits-1:0]   byte_sel;
    } addr_fields_t;

    // same 32 bits, seen flat or as fields
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } cache_addr_u;

    // controller states
    typedef enum logic [1:0] {
        idle    = 2'd0,
        compare = 2'd1,
        memory  = 2'd2,
        update  = 2'd3
    } ctrl_state_e;

endpackage

/* hdl/dcache_tag_store.sv */
`timescale 1ns/1ps

module dcache_tag_store import dcache_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_addr_u         lookup_addr,
    input  cache_addr_u         req_addr,
    input  logic                lru_touch,
    input  logic                line_alloc,
    input  logic                alloc_dirty,
    input  logic                wr_hit,
    output logic [1:0]          hit_way,
    output logic                victim_way,
    output logic                victim_dirty,
    output logic [tag_bits-1:0] victim_tag
);

    localparam int sets = 2 ** index_bits;

    logic [tag_bits-1:0]   tag_ram [2][sets];
    logic [tag_bits-1:0]   tag_q [2];
    logic [1:0][sets-1:0]  valid_q;
    logic [1:0][sets-1:0]  dirty_q;
    // per set, the way to replace next
    logic [sets-1:0]       lru_q;
    logic [index_bits-1:0] req_idx;

    assign req_idx = req_addr.f.index;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            tag_q[w] <= tag_ram[w][lookup_addr.f.index];
        end
        if (line_alloc) begin
            tag_ram[victim_way][req_idx] <= req_addr.f.tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (line_alloc) begin
                valid_q[victim_way][req_idx] <= 1'b1;
                dirty_q[victim_way][req_idx] <= alloc_dirty;
                lru_q[req_idx]               <= ~victim_way;
            end
            if (wr_hit) begin
                dirty_q[hit_way[1]][req_idx] <= 1'b1;
            end
            // point at the way that was not used
            if (lru_touch) begin
                lru_q[req_idx] <= hit_way[0];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way[w] = valid_q[w][req_idx] && (tag_q[w] == req_addr.f.tag);
        end
    end

    assign victim_way   = lru_q[req_idx];
    assign victim_dirty = dirty_q[victim_way][req_idx];
    assign victim_tag   = tag_q[victim_way];

    // allocation never leaves one tag valid in both ways
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(hit_way)
    );

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    // processor side
    input  logic [31:0] addr,
    input  logic        rd_en,
    input  logic [3:0]  wr_be,
    input  logic [31:0] wr_data,
    output logic [31:0] rd_data,
    output logic        rd_valid,
    output logic        wr_done,
    // memory read address and data
    output logic [31:0] ar_addr,
    output logic        ar_valid,
    input  logic        ar_ready,
    input  logic [31:0] r_data,
    input  logic        r_valid,
    input  logic        r_last,
    output logic        r_ready,
    // memory write address and data
    output logic [31:0] aw_addr,
    output logic        aw_valid,
    input  logic        aw_ready,
    output logic [31:0] w_data,
    output logic        w_valid,
    output logic        w_last,
    input  logic        w_ready
);

    cache_addr_u                         req_addr;
    cache_addr_u                         lookup_addr;
    logic [1:0]                          hit_way;
    logic                                victim_way;
    logic                                victim_dirty;
    logic [tag_bits-1:0]                 victim_tag;
    logic [line_words-1:0][31:0]         victim_line;
    logic [31:0]                         hit_word;
    logic                                lru_touch;
    logic                                wr_hit;
    logic                                line_alloc;
    logic                                alloc_dirty;
    logic                                fill_start;
    logic                                wb_start;
    logic [offset_bits-1:0]              fill_beat;
    logic                                fill_we;
    logic [31:0]                         fill_data;
    logic                                fill_done;
    logic                                wb_done;
    logic [1:0][line_words-1:0][3:0]     bank_we;
    logic [31:0]                         bank_wdata;

    dcache_ctrl u_ctrl (.*);

    dcache_tag_store u_tag_store (.*);

    dcache_data_store u_data_store (.*);

    dcache_bus_master u_bus_master (.*);

endmodule

/* verif/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int mem_words  = 4096;
    localparam int max_ops    = 400;
    localparam int op_cycles  = 64;
    localparam int op_timeout = 200;

    logic        clk;
    logic        arst_n;
    logic [31:0] addr;
    logic        rd_en;
    logic [3:0]  wr_be;
    logic [31:0] wr_data;
    logic [31:0] rd_data;
    logic        rd_valid;
    logic        wr_done;
    logic [31:0] ar_addr;
    logic [31:0] r_data;
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic        ar_valid;
    logic        ar_ready;
    logic        r_valid;
    logic        r_last;
    logic        r_ready;
    logic        aw_valid;
    logic        aw_ready;
    logic        w_valid;
    logic        w_last;
    logic        w_ready;

    logic [31:0] shadow [mem_words];
    cache_addr_u cur_addr;
    cache_addr_u last_ar;
    cache_addr_u last_aw;
    cache_addr_u evicted [$];
    int          ar_count = 0;
    int          aw_count = 0;
    int          w_beats = 0;
    int          w_in_burst = 0;
    int          cycles = 0;
    int          lat;
    integer      seed = 50;

    dcache_top UUT (.*);

    tb_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [11:0] word_index(input cache_addr_u a);
        return {a.f.tag[3:0], a.f.index[4:0], a.f.offset};
    endfunction

    function automatic logic [31:0] ref_read(input cache_addr_u a);
        return shadow[word_index(a)];
    endfunction

    function automatic cache_addr_u make_addr(input int tag, input int set, input int word);
        cache_addr_u a;
        a.word     = '0;
        a.f.tag    = tag_bits'(tag);
        a.f.index  = index_bits'(set);
        a.f.offset = offset_bits'(word);
        return a;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input cache_addr_u got, input cache_addr_u exp);
        if (got.word !== exp.word) begin
            stop_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, what, got.word, exp.word));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // memory line after a writeback against the shadow
    task automatic check_line(input cache_addr_u base);
        logic [line_words-1:0][31:0] got;
        logic [line_words-1:0][31:0] exp;
        for (int i = 0; i < line_words; i++) begin
            got[i] = u_mem.mem[word_index(base) + 12'(i)];
            exp[i] = shadow[word_index(base) + 12'(i)];
        end
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: line %h in memory is %h, expected %h",
                               $time, base.word, got, exp));
        end
    endtask

    // drive one request for a cycle and wait for its completion pulse
    task automatic run_op(input cache_addr_u a, input logic rd, input logic [3:0] be,
                          input logic [31:0] data);
        ctrl_state_e st;
        @(negedge clk);
        cur_addr = a;
        addr     = a.word;
        rd_en    = rd;
        wr_be    = be;
        wr_data  = data;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                shadow[word_index(a)][i*8 +: 8] = data[i*8 +: 8];
            end
        end
        @(negedge clk);
        rd_en = 1'b0;
        wr_be = 4'b0;
        lat   = 1;
        while (!(rd_valid || wr_done)) begin
            if (lat >= op_timeout) begin
                st = UUT.u_ctrl.state;
                stop_run($sformatf("no rd_valid or wr_done within %0d cycles, controller in %s",
                                   op_timeout, st.name()));
            end
            @(negedge clk);
            lat++;
        end
        check_flag("rd_valid at completion", rd_valid, rd);
        check_flag("wr_done at completion", wr_done, !rd);
        while (evicted.size() > 0) begin
            check_line(evicted.pop_front());
        end
    endtask

    // every returned word against the shadow
    always @(negedge clk) begin
        if (arst_n && rd_valid) begin
            check_word("read data", rd_data, ref_read(cur_addr));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_ops * op_cycles) begin
            stop_run($sformatf("run did not finish within %0d cycles", cycles));
        end
        if (ar_valid && ar_ready) begin
            ar_count++;
            last_ar = cache_addr_u'(ar_addr);
        end
        if (aw_valid && aw_ready) begin
            aw_count++;
            w_in_burst = 0;
            last_aw = cache_addr_u'(aw_addr);
            evicted.push_back(cache_addr_u'(aw_addr));
        end
        if (w_valid && w_ready) begin
            check_flag("w_last", w_last, w_in_burst == 7);
            w_in_burst++;
            w_beats++;
        end
    end

    initial begin
        cache_addr_u a;
        logic [31:0] r;
        int          n;
        int          m;
        addr    = '0;
        rd_en   = 1'b0;
        wr_be   = 4'b0;
        wr_data = '0;
        arst_n  = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = u_mem.mem[i];
        end

        // read miss fetches the aligned line
        n = ar_count;
        run_op(make_addr(1, 3, 5), 1'b1, 4'b0, 32'h0);
        check_count("refill bursts on read miss", ar_count - n, 1);
        check_addr("refill address", last_ar, make_addr(1, 3, 0));
        n = ar_count;
        run_op(make_addr(1, 3, 2), 1'b1, 4'b0, 32'h0);
        check_count("read hit latency", lat, 1);
        check_count("refill bursts on read hit", ar_count - n, 0);

        // byte write hit and a read of the merged word
        run_op(make_addr(1, 3, 2), 1'b0, 4'b0101, 32'hdead_beef);
        check_count("write hit latency", lat, 2);
        run_op(make_addr(1, 3, 2), 1'b1, 4'b0, 32'h0);

        // A and B share set 9 and A is used again so C replaces B
        run_op(make_addr(2, 9, 0), 1'b1, 4'b0, 32'h0);
        run_op(make_addr(3, 9, 1), 1'b1, 4'b0, 32'h0);
        run_op(make_addr(2, 9, 4), 1'b1, 4'b0, 32'h0);
        run_op(make_addr(4, 9, 6), 1'b1, 4'b0, 32'h0);
        n = ar_count;
        run_op(make_addr(2, 9, 7), 1'b1, 4'b0, 32'h0);
        check_count("bursts on read of kept line", ar_count - n, 0);
        run_op(make_addr(3, 9, 3), 1'b1, 4'b0, 32'h0);
        check_count("bursts on read of replaced line", ar_count - n, 1);

        // two dirty lines in set 12 and the older one goes back to memory
        run_op(make_addr(5, 12, 1), 1'b0, 4'b1111, 32'h1234_5678);
        run_op(make_addr(6, 12, 4), 1'b0, 4'b0011, 32'h0bad_cafe);
        n = aw_count;
        m = w_beats;
        run_op(make_addr(7, 12, 0), 1'b1, 4'b0, 32'h0);
        check_count("writeback bursts", aw_count - n, 1);
        check_count("writeback beats", w_beats - m, 8);
        check_addr("writeback address", last_aw, make_addr(5, 12, 0));

        // random mix of 16 tags over sets 20 to 23
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            a = make_addr(int'(r[3:0]), 20 + int'(r[5:4]), int'(r[8:6]));
            if (r[9]) begin
                run_op(a, 1'b1, 4'b0, 32'h0);
            end else begin
                run_op(a, 1'b0, (r[13:10] == 4'b0) ? 4'hf : r[13:10], $random(seed));
            end
        end
        check_count("beats over all writebacks", w_beats, 8 * aw_count);

        $display("Test OK");
        $finish;
    end

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk,
    input  logic [31:0] ar_addr,
    input  logic        ar_valid,
    output logic        ar_ready,
    output logic [31:0] r_data,
    output logic        r_valid,
    output logic        r_last,
    input  logic        r_ready,
    input  logic [31:0] aw_addr,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] w_data,
    input  logic        w_valid,
    output logic        w_ready
);

    logic [31:0] mem [4096];
    integer      seed = 50;
    logic [11:0] rd_ptr;
    logic [11:0] wr_ptr;
    int          rd_left;
    int          ar_wait;
    int          r_wait;
    int          aw_wait;
    int          w_wait;

    // word index from tag bits 3:0, set bits 4:0 and word offset
    function automatic logic [11:0] word_index(input logic [31:0] a);
        return {a[15:12], a[9:2]};
    endfunction

    function automatic int pick_delay();
        return int'({$random(seed)} % 4);
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {i[11:0], 4'h5, ~i[11:0], 4'ha};
        end
        rd_left  = 0;
        ar_wait  = 0;
        r_wait   = 0;
        aw_wait  = 0;
        w_wait   = 0;
        rd_ptr   = '0;
        wr_ptr   = '0;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        r_last   = 1'b0;
        r_data   = '0;
    end

    // handshakes as the DUT sees them at the rising edge
    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            rd_ptr  = word_index(ar_addr);
            rd_left = 8;
            ar_wait = pick_delay();
        end else if (ar_valid && ar_wait > 0) begin
            ar_wait--;
        end
        if (r_valid && r_ready) begin
            rd_ptr++;
            rd_left--;
            r_wait = pick_delay();
        end else if (rd_left > 0 && r_wait > 0) begin
            r_wait--;
        end
        if (aw_valid && aw_ready) begin
            wr_ptr  = word_index(aw_addr);
            aw_wait = pick_delay();
        end else if (aw_valid && aw_wait > 0) begin
            aw_wait--;
        end
        if (w_valid && w_ready) begin
            mem[wr_ptr] = w_data;
            wr_ptr++;
            w_wait = pick_delay();
        end else if (w_valid && w_wait > 0) begin
            w_wait--;
        end
    end

    always @(negedge clk) begin
        ar_ready = (ar_wait == 0);
        aw_ready = (aw_wait == 0);
        w_ready  = (w_wait == 0);
        r_valid  = (rd_left > 0) && (r_wait == 0);
        r_data   = mem[rd_ptr];
        r_last   = (rd_left == 1);
    end

endmodule
